//--- common/rv32i_consts.svh
`ifndef RV32I_CONSTS_SVH
`define RV32I_CONSTS_SVH

// first fetch address after reset
`define RESET_PC 32'h0000_0100

// major opcodes, instr[6:0]
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_LUI    7'b0110111
`define OPC_JAL    7'b1101111

// funct3 codes, instr[14:12]
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111
`define F3_WORD 3'b010
`define F3_BEQ  3'b000
`define F3_BNE  3'b001

// funct7 codes, instr[31:25]
`define F7_BASE 7'b0000000
`define F7_ALT  7'b0100000

// the only system instruction this core knows
`define ECALL_WORD 32'h0000_0073

`endif

//--- common/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

  typedef logic [31:0] word_t;      // data or address word
  typedef logic [4:0]  reg_addr_t;  // register index

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_pass_b  // lui passes the U immediate straight through
  } alu_op_t;

  typedef enum logic [3:0] {
    cls_alu_reg,
    cls_alu_imm,
    cls_load,
    cls_store,
    cls_branch,
    cls_lui,
    cls_jal,
    cls_system,
    cls_illegal
  } instr_class_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  write;  // low for reads and fetches
  } mem_req_t;

  typedef struct packed {
    instr_class_t iclass;
    alu_op_t      alu_op;
    reg_addr_t    rs1;
    reg_addr_t    rs2;
    reg_addr_t    rd;
    logic         bne;  // branch when operands differ
    word_t        imm;  // already sign extended
  } ctrl_t;

endpackage

`default_nettype wire

//--- rv32i_core/rv32i_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module rv32i_mem_port (
  input  wire                     clk,
  input  wire                     rst,
  input  wire rv32i_pkg::mem_req_t core_req,
  input  wire                     core_req_valid,
  output logic                    core_req_ready,
  output logic                    core_rsp_valid,
  output rv32i_pkg::word_t        core_rsp_data,
  output rv32i_pkg::mem_req_t     mem_req,
  output logic                    mem_req_valid,
  input  wire                     mem_req_ready,
  input  wire                     mem_rsp_valid,
  input  wire rv32i_pkg::word_t   mem_rsp_data
);
  import rv32i_pkg::*;

  logic  read_pending;  // a read went out and its data has not come back
  word_t rsp_hold;

  // only one request in the whole system at a time
  assign core_req_ready = !mem_req_valid && !read_pending;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_req       <= '0;
      mem_req_valid <= 1'b0;
      read_pending  <= 1'b0;
    end else begin
      if (core_req_valid && core_req_ready) begin
        mem_req       <= core_req;
        mem_req_valid <= 1'b1;
      end else if (mem_req_valid && mem_req_ready) begin
        mem_req_valid <= 1'b0;
        read_pending  <= !mem_req.write;  // writes are never answered
      end
      if (mem_rsp_valid) begin
        read_pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_rsp_valid) begin
      rsp_hold <= mem_rsp_data;
    end
  end

  assign core_rsp_valid = mem_rsp_valid;
  assign core_rsp_data  = mem_rsp_valid ? mem_rsp_data : rsp_hold;  // last word between pulses

  hold_stable: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

  rsp_expected: assert property (@(posedge clk) disable iff (rst)
    mem_rsp_valid |-> read_pending);

endmodule

`default_nettype wire

//--- rv32i_core/rv32i_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_consts.svh"

module rv32i_decoder (
  input  wire rv32i_pkg::word_t instr,
  output rv32i_pkg::ctrl_t      ctrl
);
  import rv32i_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       alt;
  logic       reg_f7_ok;
  logic       imm_f7_ok;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  alu_op_t    arith_op;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign alt    = (funct7 == `F7_ALT);

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // alt funct7 is only legal on sub and sra
  assign reg_f7_ok = (funct7 == `F7_BASE) || (alt && (funct3 == `F3_ADD || funct3 == `F3_SR));
  assign imm_f7_ok = (funct3 == `F3_SLL) ? (funct7 == `F7_BASE) :
                     (funct3 == `F3_SR)  ? (funct7 == `F7_BASE || alt) : 1'b1;

  // same funct3 table for both register and immediate forms
  always_comb begin
    case (funct3)
      `F3_ADD:  arith_op = (alt && opcode == `OPC_OP) ? alu_sub : alu_add;  // no subi
      `F3_SLL:  arith_op = alu_sll;
      `F3_SLT:  arith_op = alu_slt;
      `F3_SLTU: arith_op = alu_sltu;
      `F3_XOR:  arith_op = alu_xor;
      `F3_SR:   arith_op = alt ? alu_sra : alu_srl;
      `F3_OR:   arith_op = alu_or;
      default:  arith_op = alu_and;
    endcase
  end

  always_comb begin
    ctrl        = '0;
    ctrl.iclass = cls_illegal;
    ctrl.alu_op = alu_add;
    ctrl.rs1    = instr[19:15];
    ctrl.rs2    = instr[24:20];
    ctrl.rd     = instr[11:7];
    ctrl.bne    = (funct3 == `F3_BNE);
    ctrl.imm    = imm_i;
    case (opcode)
      `OPC_OP: begin
        if (reg_f7_ok) begin
          ctrl.iclass = cls_alu_reg;
          ctrl.alu_op = arith_op;
        end
      end
      `OPC_OP_IMM: begin
        if (imm_f7_ok) begin
          ctrl.iclass = cls_alu_imm;
          ctrl.alu_op = arith_op;
        end
      end
      `OPC_LOAD: begin
        if (funct3 == `F3_WORD) ctrl.iclass = cls_load;  // lw only
      end
      `OPC_STORE: begin
        if (funct3 == `F3_WORD) ctrl.iclass = cls_store;
        ctrl.imm = imm_s;
      end
      `OPC_BRANCH: begin
        if (funct3 == `F3_BEQ || funct3 == `F3_BNE) ctrl.iclass = cls_branch;
        ctrl.alu_op = alu_sub;
        ctrl.imm    = imm_b;
      end
      `OPC_LUI: begin
        ctrl.iclass = cls_lui;
        ctrl.alu_op = alu_pass_b;
        ctrl.imm    = imm_u;
      end
      `OPC_JAL: begin
        ctrl.iclass = cls_jal;
        ctrl.imm    = imm_j;
      end
      default: begin
        if (instr == `ECALL_WORD) ctrl.iclass = cls_system;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rv32i_core/rv32i_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv32i_alu (
  input  wire rv32i_pkg::word_t   a,
  input  wire rv32i_pkg::word_t   b,
  input  wire rv32i_pkg::alu_op_t op,
  output rv32i_pkg::word_t        result,
  output logic                    equal
);
  import rv32i_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];  // upper bits of the shift amount are ignored
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_and:    result = a & b;
      alu_or:     result = a | b;
      alu_xor:    result = a ^ b;
      alu_sll:    result = a << shamt;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = $signed(a) >>> shamt;
      alu_slt:    result = {31'b0, lt_signed};
      alu_sltu:   result = {31'b0, lt_unsigned};
      alu_pass_b: result = b;
      default:    result = a + b;
    endcase
  end

  // beq and bne only need equality
  assign equal = (a == b);

endmodule

`default_nettype wire

//--- rv32i_core/rv32i_register_file.sv
`timescale 1ns/1ps
`default_nettype none

module rv32i_register_file (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       wr_en,
  input  wire rv32i_pkg::reg_addr_t wr_addr,
  input  wire rv32i_pkg::word_t     wr_data,
  input  wire rv32i_pkg::reg_addr_t rd_addr0,
  input  wire rv32i_pkg::reg_addr_t rd_addr1,
  output rv32i_pkg::word_t          rd_data0,
  output rv32i_pkg::word_t          rd_data1
);
  import rv32i_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin  // x0 stays zero
      regs[wr_addr] <= wr_data;
    end
  end

  assign rd_data0 = regs[rd_addr0];
  assign rd_data1 = regs[rd_addr1];

endmodule

`default_nettype wire

//--- rv32i_core/rv32i_multicycle_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_consts.svh"

module rv32i_multicycle_core (
  input  wire                   clk,
  input  wire                   rst,
  output rv32i_pkg::mem_req_t   req,
  output logic                  req_valid,
  input  wire                   req_ready,
  input  wire                   rsp_valid,
  input  wire rv32i_pkg::word_t rsp_data,
  output logic                  halted
);
  import rv32i_pkg::*;

  typedef enum logic [2:0] {
    st_fetch,
    st_fetch_wait,
    st_decode,
    st_execute,
    st_mem,
    st_mem_wait,
    st_writeback,
    st_halt
  } state_t;

  state_t state;
  word_t  pc, old_pc, instr;
  word_t  op_a, op_b, store_data;
  word_t  alu_result, load_data;
  word_t  rs1_data, rs2_data, alu_out;
  word_t  branch_target, link_addr, wb_data;
  ctrl_t  ctrl;
  logic   alu_equal;
  logic   branch_taken;
  logic   use_rs2;

  rv32i_decoder i_decoder (
    .instr (instr),
    .ctrl  (ctrl)
  );

  rv32i_register_file i_register_file (
    .clk      (clk),
    .rst      (rst),
    .wr_en    (state == st_writeback),
    .wr_addr  (ctrl.rd),
    .wr_data  (wb_data),
    .rd_addr0 (ctrl.rs1),
    .rd_addr1 (ctrl.rs2),
    .rd_data0 (rs1_data),
    .rd_data1 (rs2_data)
  );

  rv32i_alu i_alu (
    .a      (op_a),
    .b      (op_b),
    .op     (ctrl.alu_op),
    .result (alu_out),
    .equal  (alu_equal)
  );

  assign use_rs2       = (ctrl.iclass == cls_alu_reg) || (ctrl.iclass == cls_branch);
  assign branch_taken  = alu_equal ^ ctrl.bne;
  assign branch_target = old_pc + ctrl.imm;  // shared by branches and jal
  assign link_addr     = old_pc + 32'd4;

  always_comb begin
    case (ctrl.iclass)
      cls_load: wb_data = load_data;
      cls_jal:  wb_data = link_addr;
      default:  wb_data = alu_result;
    endcase
  end

  // fetches read pc, the mem state sends the lw/sw address
  assign req_valid   = (state == st_fetch) || (state == st_mem);
  assign req.addr    = (state == st_mem) ? alu_result : pc;
  assign req.wdata   = store_data;
  assign req.write   = (state == st_mem) && (ctrl.iclass == cls_store);
  assign halted      = (state == st_halt);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_fetch;
      pc    <= `RESET_PC;
    end else begin
      case (state)
        st_fetch: begin
          if (req_ready) begin
            old_pc <= pc;
            pc     <= pc + 32'd4;
            state  <= st_fetch_wait;
          end
        end
        st_fetch_wait: begin
          if (rsp_valid) begin
            instr <= rsp_data;
            state <= st_decode;
          end
        end
        st_decode: begin
          op_a       <= rs1_data;
          op_b       <= use_rs2 ? rs2_data : ctrl.imm;
          store_data <= rs2_data;
          case (ctrl.iclass)
            cls_system:  state <= st_halt;
            cls_illegal: state <= st_fetch;  // skipped, pc already moved on
            default:     state <= st_execute;
          endcase
        end
        st_execute: begin
          alu_result <= alu_out;
          case (ctrl.iclass)
            cls_load, cls_store: state <= st_mem;
            cls_branch: begin
              if (branch_taken) pc <= branch_target;
              state <= st_fetch;
            end
            cls_jal: begin
              pc    <= branch_target;
              state <= st_writeback;
            end
            default: state <= st_writeback;
          endcase
        end
        st_mem: begin
          if (req_ready) begin
            state <= (ctrl.iclass == cls_store) ? st_fetch : st_mem_wait;
          end
        end
        st_mem_wait: begin
          if (rsp_valid) begin
            load_data <= rsp_data;
            state     <= st_writeback;
          end
        end
        st_writeback: state <= st_fetch;
        default:      state <= st_halt;
      endcase
    end
  end

  // once halted the core never asks for memory again
  halt_quiet: assert property (@(posedge clk) disable iff (rst)
    halted |=> halted && !req_valid);

endmodule

`default_nettype wire

//--- verilog/rv32i_system.sv
`timescale 1ns/1ps
`default_nettype none

module rv32i_system (
  input  wire                   clk,
  input  wire                   rst,
  output rv32i_pkg::mem_req_t   mem_req,
  output logic                  mem_req_valid,
  input  wire                   mem_req_ready,
  input  wire                   mem_rsp_valid,
  input  wire rv32i_pkg::word_t mem_rsp_data,
  output logic                  halted
);
  import rv32i_pkg::*;

  mem_req_t core_req;
  logic     core_req_valid;
  logic     core_req_ready;
  logic     core_rsp_valid;
  word_t    core_rsp_data;

  rv32i_multicycle_core i_core (
    .clk       (clk),
    .rst       (rst),
    .req       (core_req),
    .req_valid (core_req_valid),
    .req_ready (core_req_ready),
    .rsp_valid (core_rsp_valid),
    .rsp_data  (core_rsp_data),
    .halted    (halted)
  );

  rv32i_mem_port i_mem_port (
    .clk            (clk),
    .rst            (rst),
    .core_req       (core_req),
    .core_req_valid (core_req_valid),
    .core_req_ready (core_req_ready),
    .core_rsp_valid (core_rsp_valid),
    .core_rsp_data  (core_rsp_data),
    .mem_req        (mem_req),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_rsp_valid  (mem_rsp_valid),
    .mem_rsp_data   (mem_rsp_data)
  );

endmodule

`default_nettype wire

//--- tb/tb_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_memory (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      delays_on,
  input  wire rv32i_pkg::mem_req_t mem_req,
  input  wire                      mem_req_valid,
  output logic                     mem_req_ready,
  output logic                     mem_rsp_valid,
  output rv32i_pkg::word_t         mem_rsp_data
);
  import rv32i_pkg::*;

  word_t       mem [2048];  // 8 KiB, byte address bits 12:2 pick the word
  int unsigned ready_wait;
  int unsigned rsp_wait;
  logic        rsp_pending;
  word_t       rsp_word;
  logic        took;
  mem_req_t    took_req;

  task automatic load_word(input word_t addr, input word_t data);
    mem[addr[12:2]] = data;
  endtask

  function automatic int unsigned pick_delay();
    return delays_on ? ($urandom % 4) : 0;  // 0 to 3 extra cycles
  endfunction

  // the DUT sees a transfer at the rising edge, so note it there
  always @(posedge clk) begin
    took     <= !rst && mem_req_valid && mem_req_ready;
    took_req <= mem_req;
  end

  initial begin
    void'($urandom(99074));  // seeds the generator for the whole run
    for (int i = 0; i < 2048; i++) begin
      mem[i] = 32'hbad0_0000 | (i << 2);  // unwritten words read back their own address
    end
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp_data  = '0;
    rsp_pending   = 1'b0;
    rsp_word      = '0;
    ready_wait    = 0;
    rsp_wait      = 0;
    forever begin
      @(negedge clk);
      mem_rsp_valid = 1'b0;
      if (rst) begin
        rsp_pending   = 1'b0;
        mem_req_ready = 1'b0;
        ready_wait    = pick_delay();
      end else begin
        if (took) begin
          if (took_req.write) begin
            mem[took_req.addr[12:2]] = took_req.wdata;
          end else begin
            rsp_pending = 1'b1;
            rsp_word    = mem[took_req.addr[12:2]];
            rsp_wait    = pick_delay();
          end
          ready_wait = pick_delay();
        end
        if (rsp_pending) begin
          if (rsp_wait == 0) begin
            mem_rsp_valid = 1'b1;
            mem_rsp_data  = rsp_word;
            rsp_pending   = 1'b0;
          end else begin
            rsp_wait--;
          end
        end
        mem_req_ready = 1'b0;
        if (mem_req_valid && !took) begin
          if (ready_wait == 0) begin
            mem_req_ready = 1'b1;
          end else begin
            ready_wait--;  // back-pressure
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/rv32i_system_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_consts.svh"

module rv32i_system_tb;
  import rv32i_pkg::*;

  localparam word_t DATA_BASE  = 32'h0000_1000;  // result slots, 4 bytes each
  localparam int    MAX_CYCLES = 4000;  // two passes of ~60 instructions, 30 cycles at most each

  logic     clk;
  logic     rst;
  logic     delays_on;
  mem_req_t mem_req;
  logic     mem_req_valid;
  logic     mem_req_ready;
  logic     mem_rsp_valid;
  word_t    mem_rsp_data;
  logic     halted;

  word_t prog [64];
  int    prog_len;
  word_t exp_fetch [64];
  int    fetch_len;
  word_t exp_data [32];
  logic  exp_valid [32];
  string test_name [32];
  logic  seen [32];
  int    fetch_idx;
  logic  first_done;
  int    mismatches = 0;
  int    failures   = 0;
  int    cycles     = 0;

  logic       xfer, store_xfer, fetch_xfer, in_window;
  logic [4:0] slot;
  word_t      next_fetch;

  rv32i_system i_dut (
    .clk           (clk),
    .rst           (rst),
    .mem_req       (mem_req),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_data  (mem_rsp_data),
    .halted        (halted)
  );

  tb_memory i_mem (
    .clk           (clk),
    .rst           (rst),
    .delays_on     (delays_on),
    .mem_req       (mem_req),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_data  (mem_rsp_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  assign xfer       = mem_req_valid && mem_req_ready;
  assign store_xfer = xfer && mem_req.write;
  assign fetch_xfer = xfer && !mem_req.write && mem_req.addr < DATA_BASE;
  assign in_window  = mem_req.addr[31:7] == DATA_BASE[31:7];
  assign slot       = mem_req.addr[6:2];
  assign next_fetch = (fetch_idx < fetch_len) ? exp_fetch[fetch_idx] : 32'hffff_ffff;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the core did not halt within %0d cycles", MAX_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      fetch_idx  <= 0;
      first_done <= 1'b0;
      for (int k = 0; k < 32; k++) begin
        seen[k] <= 1'b0;
      end
    end else begin
      if (xfer) first_done <= 1'b1;
      if (fetch_xfer) fetch_idx <= fetch_idx + 1;
      if (store_xfer && in_window) seen[slot] <= 1'b1;
    end
  end

  reset_quiet: assert property (@(posedge clk) rst |=> !mem_req_valid && !mem_req.write && !halted)
    else begin failures++; $display("request valid, write or halted was high after reset"); end

  first_fetch: assert property (@(posedge clk) disable iff (rst)
    xfer && !first_done |-> !mem_req.write && mem_req.addr == `RESET_PC)
    else begin
      mismatches++;
      $display("Mismatch first_fetch: expected %h, actual %h", `RESET_PC, $sampled(mem_req.addr));
    end

  fetch_order: assert property (@(posedge clk) disable iff (rst)
    fetch_xfer |-> mem_req.addr == next_fetch)
    else begin
      mismatches++;
      $display("Mismatch fetch_%0d: expected %h, actual %h", $sampled(fetch_idx),
               $sampled(next_fetch), $sampled(mem_req.addr));
    end

  store_known: assert property (@(posedge clk) disable iff (rst)
    store_xfer |-> in_window && exp_valid[slot])
    else begin failures++; $display("store to %h was not expected", $sampled(mem_req.addr)); end

  store_value: assert property (@(posedge clk) disable iff (rst)
    store_xfer && in_window && exp_valid[slot] |-> mem_req.wdata == exp_data[slot])
    else begin
      mismatches++;
      $display("Mismatch %s: expected %h, actual %h", test_name[$sampled(slot)],
               exp_data[$sampled(slot)], $sampled(mem_req.wdata));
    end

  req_hold: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
    else begin failures++; $display("memory request changed while it was held"); end

  halt_stays: assert property (@(posedge clk) disable iff (rst)
    halted |=> halted && !mem_req_valid)
    else begin failures++; $display("the core dropped halt or requested memory after ecall"); end

  function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3,
                                   input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, `OPC_OP};
  endfunction

  function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                   input logic [2:0] f3, input reg_addr_t rd,
                                   input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t s_word(input logic [11:0] off, input reg_addr_t rs2,
                                   input reg_addr_t rs1);
    return {off[11:5], rs2, rs1, `F3_WORD, off[4:0], `OPC_STORE};
  endfunction

  function automatic word_t b_type(input logic [12:0] off, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
  endfunction

  function automatic word_t j_type(input logic [20:0] off, input reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
  endfunction

  function automatic word_t u_type(input logic [19:0] upper, input reg_addr_t rd);
    return {upper, rd, `OPC_LUI};
  endfunction

  // skipped words go into the image but not into the fetch trace
  task automatic emit(input word_t instr, input logic runs);
    if (runs) begin
      exp_fetch[fetch_len] = `RESET_PC + word_t'(4 * prog_len);
      fetch_len++;
    end
    prog[prog_len] = instr;
    prog_len++;
  endtask

  task automatic expect_store(input int k, input string name, input word_t value);
    exp_valid[k] = 1'b1;
    exp_data[k]  = value;
    test_name[k] = name;
  endtask

  // result lands in x9, then goes to slot k
  task automatic alu_test(input int k, input string name, input word_t instr,
                          input word_t expected);
    emit(instr, 1'b1);
    emit(s_word(12'(4 * k), 5'd9, 5'd10), 1'b1);
    expect_store(k, name, expected);
  endtask

  task automatic build_program();
    word_t a, b, c, jal_pc;
    a         = 32'hffff_ffec;  // -20
    b         = 32'd3;
    c         = 32'h1234_5678;
    prog_len  = 0;
    fetch_len = 0;
    for (int k = 0; k < 32; k++) begin
      exp_valid[k] = 1'b0;
      exp_data[k]  = '0;
      test_name[k] = "none";
    end
    emit(i_type(12'hfec, 5'd0, `F3_ADD, 5'd1, `OPC_OP_IMM), 1'b1);
    emit(i_type(12'd3, 5'd0, `F3_ADD, 5'd2, `OPC_OP_IMM), 1'b1);
    emit(u_type(20'h12345, 5'd3), 1'b1);
    emit(i_type(12'h678, 5'd3, `F3_ADD, 5'd3, `OPC_OP_IMM), 1'b1);
    emit(u_type(20'h00001, 5'd10), 1'b1);  // x10 points at the result slots
    alu_test(0, "add", r_type(`F7_BASE, 5'd2, 5'd1, `F3_ADD, 5'd9), a + b);
    alu_test(1, "sub", r_type(`F7_ALT, 5'd2, 5'd1, `F3_ADD, 5'd9), a - b);
    alu_test(2, "and", r_type(`F7_BASE, 5'd2, 5'd1, `F3_AND, 5'd9), a & b);
    alu_test(3, "or", r_type(`F7_BASE, 5'd2, 5'd1, `F3_OR, 5'd9), a | b);
    alu_test(4, "xor", r_type(`F7_BASE, 5'd2, 5'd1, `F3_XOR, 5'd9), a ^ b);
    alu_test(5, "sll", r_type(`F7_BASE, 5'd2, 5'd3, `F3_SLL, 5'd9), c << b[4:0]);
    alu_test(6, "srl", r_type(`F7_BASE, 5'd2, 5'd1, `F3_SR, 5'd9), a >> b[4:0]);
    alu_test(7, "sra", r_type(`F7_ALT, 5'd2, 5'd1, `F3_SR, 5'd9), $signed(a) >>> b[4:0]);
    alu_test(8, "slt", r_type(`F7_BASE, 5'd2, 5'd1, `F3_SLT, 5'd9),
             {31'b0, $signed(a) < $signed(b)});
    alu_test(9, "sltu", r_type(`F7_BASE, 5'd2, 5'd1, `F3_SLTU, 5'd9), {31'b0, a < b});
    alu_test(10, "addi", i_type(12'd100, 5'd1, `F3_ADD, 5'd9, `OPC_OP_IMM), a + 32'd100);
    alu_test(11, "andi", i_type(12'hf00, 5'd3, `F3_AND, 5'd9, `OPC_OP_IMM), c & 32'hffff_ff00);
    alu_test(12, "ori", i_type(12'h0f0, 5'd2, `F3_OR, 5'd9, `OPC_OP_IMM), b | 32'h0000_00f0);
    alu_test(13, "xori", i_type(12'hfff, 5'd1, `F3_XOR, 5'd9, `OPC_OP_IMM), ~a);
    alu_test(14, "slli", i_type(12'd4, 5'd3, `F3_SLL, 5'd9, `OPC_OP_IMM), c << 4);
    alu_test(15, "srli", i_type(12'd28, 5'd1, `F3_SR, 5'd9, `OPC_OP_IMM), a >> 28);
    alu_test(16, "srai", i_type({`F7_ALT, 5'd2}, 5'd1, `F3_SR, 5'd9, `OPC_OP_IMM),
             $signed(a) >>> 2);
    alu_test(17, "slti", i_type(12'hffb, 5'd1, `F3_SLT, 5'd9, `OPC_OP_IMM),
             {31'b0, $signed(a) < -32'sd5});
    alu_test(18, "sltiu", i_type(12'hfff, 5'd2, `F3_SLTU, 5'd9, `OPC_OP_IMM),
             {31'b0, b < 32'hffff_ffff});
    alu_test(19, "lui", u_type(20'habcde, 5'd9), 32'habcd_e000);
    emit(s_word(12'd80, 5'd3, 5'd10), 1'b1);
    expect_store(20, "sw", c);
    emit(i_type(12'd80, 5'd10, `F3_WORD, 5'd5, `OPC_LOAD), 1'b1);
    emit(s_word(12'd84, 5'd5, 5'd10), 1'b1);
    expect_store(21, "lw", c);
    emit(i_type(12'h011, 5'd0, `F3_ADD, 5'd6, `OPC_OP_IMM), 1'b1);  // marker
    emit(b_type(13'd8, 5'd2, 5'd2, `F3_BEQ), 1'b1);  // taken
    emit(s_word(12'd88, 5'd6, 5'd10), 1'b0);
    emit(b_type(13'd8, 5'd2, 5'd2, `F3_BNE), 1'b1);  // not taken
    emit(s_word(12'd92, 5'd6, 5'd10), 1'b1);
    expect_store(23, "bne_fall", 32'h0000_0011);
    jal_pc = `RESET_PC + word_t'(4 * prog_len);
    emit(j_type(21'd8, 5'd7), 1'b1);
    emit(s_word(12'd88, 5'd6, 5'd10), 1'b0);
    emit(s_word(12'd96, 5'd7, 5'd10), 1'b1);
    expect_store(24, "jal_link", jal_pc + 32'd4);
    emit(i_type(12'h022, 5'd0, `F3_ADD, 5'd8, `OPC_OP_IMM), 1'b1);
    emit(s_word(12'd100, 5'd8, 5'd10), 1'b1);
    expect_store(25, "jal_target", 32'h0000_0022);
    emit(32'h0000_0000, 1'b1);  // unknown opcode, just skipped
    emit(`ECALL_WORD, 1'b1);
  endtask

  task automatic run_pass(input int pass);
    delays_on = (pass != 0);
    rst       = 1'b1;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    while (!halted) @(negedge clk);
    repeat (8) @(negedge clk);  // give a stray request time to show up
    for (int k = 0; k < 32; k++) begin
      stores_seen: assert (!exp_valid[k] || seen[k])
        else begin failures++; $display("pass %0d: test %s never stored", pass, test_name[k]); end
    end
    fetch_count: assert (fetch_idx == fetch_len)
      else begin
        failures++;
        $display("pass %0d: %0d fetches seen instead of %0d", pass, fetch_idx, fetch_len);
      end
  endtask

  initial begin
    rst       = 1'b1;
    delays_on = 1'b0;
    build_program();
    @(negedge clk);
    for (int i = 0; i < prog_len; i++) begin
      i_mem.load_word(`RESET_PC + word_t'(4 * i), prog[i]);
    end
    run_pass(0);  // memory answers at once
    run_pass(1);  // random ready and response delays
    $display("mismatches: %0d, other errors: %0d", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rv32i_system.f
+incdir+common
common/rv32i_pkg.sv
rv32i_core/rv32i_mem_port.sv
rv32i_core/rv32i_decoder.sv
rv32i_core/rv32i_alu.sv
rv32i_core/rv32i_register_file.sv
rv32i_core/rv32i_multicycle_core.sv
verilog/rv32i_system.sv
tb/tb_memory.sv
tb/rv32i_system_tb.sv

//--- Bender.yml
package:
  name: rv32i_system

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/rv32i_pkg.sv
      - rv32i_core/rv32i_mem_port.sv
      - rv32i_core/rv32i_decoder.sv
      - rv32i_core/rv32i_alu.sv
      - rv32i_core/rv32i_register_file.sv
      - rv32i_core/rv32i_multicycle_core.sv
      - verilog/rv32i_system.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/tb_memory.sv
      - tb/rv32i_system_tb.sv
